// ==== hw/gfx_pkg.sv ====
package gfx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////
    localparam int VADDR_W   = 13;
    localparam int VWORD_W   = 16;
    localparam int LB_IDX_W  = 9;
    localparam int PALETTE_W = 2;
    localparam int COLOR_W   = 4;

    ////////////////////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////////////////////

    // Video RAM bus
    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [VWORD_W-1:0] vword_t;

    // Line buffer index, 512 entries per bank
    typedef logic [LB_IDX_W-1:0] lb_idx_t;

    // Palette in the upper bits, colour index below
    typedef logic [PALETTE_W-1:0] palette_t;
    typedef logic [PALETTE_W+COLOR_W-1:0] pixel_t;

    // One tile row of eight pixels, pixel 0 in the top nibble
    typedef logic [8*COLOR_W-1:0] pattern_t;

    ////////////////////////////////////////////////////////////////////////////
    // Line constants
    ////////////////////////////////////////////////////////////////////////////

    // First displayed video line
    localparam logic [7:0] FIRST_LINE = 8'd15;

    // 40 visible tiles plus one for fine scroll
    localparam int TILES_PER_LINE_DEF = 41;

endpackage

// ==== hw/gfx_fetch_fsm.sv ====
`timescale 1ns/1ps

module gfx_fetch_fsm (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic [7:0]        vline,
    input  logic [7:0]        scry,
    input  gfx_pkg::vword_t   vdata,
    input  logic [5:0]        col,
    input  logic              last_tile,
    input  logic              shifter_busy,
    input  logic              shifter_last,
    output gfx_pkg::vaddr_t   vaddr,
    output logic              map_fetch,
    output logic              tile_issue,
    output gfx_pkg::pattern_t pattern,
    output logic              hflip,
    output gfx_pkg::palette_t palette,
    output logic              line_done
);

    import gfx_pkg::*;

    typedef enum logic [2:0] {IDLE, MAP, PAT1, PAT2, DONE} state_t;

    state_t      state_r;
    state_t      state_next;
    vword_t      entry_r;
    logic [15:0] pat_hi_r;

    logic [7:0]  disp_line;
    logic [7:0]  tline;
    vword_t      entry;
    logic [8:0]  tile_idx;
    logic        tile_vflip;
    logic [2:0]  pat_row;
    vaddr_t      map_addr;
    vaddr_t      pat_addr;
    logic        can_issue;

    ////////////////////////////////////////////////////////////////////////////
    // Address generation
    ////////////////////////////////////////////////////////////////////////////
    assign disp_line = vline - FIRST_LINE;
    assign tline     = disp_line + scry;

    // Map word arrives on vdata during MAP, later from the register
    assign entry      = (state_r == MAP) ? vdata : entry_r;
    assign tile_idx   = entry[8:0];
    assign tile_vflip = entry[10];
    assign pat_row    = tile_vflip ? ~tline[2:0] : tline[2:0];

    assign map_addr = {2'b00, tline[7:3], col};
    // Even word requested from MAP, odd word from PAT1 and PAT2
    assign pat_addr = {tile_idx, pat_row, state_r != MAP};

    // Hand over when the shifter is free or finishing
    assign can_issue = !shifter_busy || shifter_last;

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        state_next = state_r;
        if (start) begin
            state_next = MAP;
        end else begin
            case (state_r)
                MAP:  state_next = PAT1;
                PAT1: state_next = PAT2;
                PAT2: begin
                    if (can_issue) begin
                        state_next = last_tile ? DONE : MAP;
                    end
                end
                default: state_next = state_r;
            endcase
        end
    end

    always_comb begin
        if (start) begin
            vaddr = map_addr;
        end else if (state_r == MAP || state_r == PAT1) begin
            vaddr = pat_addr;
        end else if (state_r == PAT2 && !can_issue) begin
            // Keep the odd word on vdata while stalled
            vaddr = pat_addr;
        end else begin
            vaddr = map_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_r <= IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state_r == MAP) begin
            entry_r <= vdata;
        end
        if (state_r == PAT1) begin
            pat_hi_r <= {vdata[7:0], vdata[15:8]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////////////////////
    assign map_fetch  = !start && (state_r == MAP);
    assign tile_issue = !start && (state_r == PAT2) && can_issue;
    assign pattern    = {pat_hi_r, vdata[7:0], vdata[15:8]};
    assign hflip      = entry_r[9];
    assign palette    = entry_r[13:12];
    assign line_done  = (state_r == DONE) && !shifter_busy;

endmodule

// ==== hw/gfx_col_counter.sv ====
`timescale 1ns/1ps

module gfx_col_counter #(
    parameter int TILES_PER_LINE = gfx_pkg::TILES_PER_LINE_DEF
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic [8:0]       scrx,
    input  logic             map_fetch,
    input  logic             tile_issue,
    output logic [5:0]       col,
    output logic             last_tile,
    output gfx_pkg::lb_idx_t tile_x
);

    import gfx_pkg::*;

    localparam int CNT_W = $clog2(TILES_PER_LINE + 1);

    logic [5:0]       col_r;
    logic [CNT_W-1:0] tile_cnt_r;

    // Coarse scroll visible in the start cycle so the first map read is right
    assign col       = start ? scrx[8:3] : col_r;
    assign last_tile = (tile_cnt_r == CNT_W'(TILES_PER_LINE));

    always_ff @(posedge clk) begin
        if (reset) begin
            col_r      <= '0;
            tile_cnt_r <= '0;
            tile_x     <= '0;
        end else if (start) begin
            col_r      <= scrx[8:3];
            tile_cnt_r <= '0;
            // Fine scroll as a negative start position, wraps mod 512
            tile_x     <= lb_idx_t'(0) - lb_idx_t'(scrx[2:0]);
        end else begin
            if (map_fetch) begin
                // Map column wraps at 64
                col_r      <= col_r + 6'd1;
                tile_cnt_r <= tile_cnt_r + CNT_W'(1);
            end
            if (tile_issue) begin
                tile_x <= tile_x + lb_idx_t'(8);
            end
        end
    end

endmodule

// ==== hw/gfx_pixel_shifter.sv ====
`timescale 1ns/1ps

module gfx_pixel_shifter (
    input  logic              clk,
    input  logic              reset,
    input  logic              load,
    input  gfx_pkg::lb_idx_t  tile_x,
    input  gfx_pkg::pattern_t pattern,
    input  logic              hflip,
    input  gfx_pkg::palette_t palette,
    output logic              busy,
    output logic              last_pixel,
    output logic              wr_en,
    output gfx_pkg::lb_idx_t  wr_idx,
    output gfx_pkg::pixel_t   wr_data
);

    import gfx_pkg::*;

    // Latched tile
    pattern_t pat_r;
    logic     hflip_r;
    palette_t pal_r;
    lb_idx_t  base_r;

    logic [2:0] cnt_r;
    logic       busy_r;

    logic [2:0] nib_sel;
    logic [3:0] color;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel select
    ////////////////////////////////////////////////////////////////////////////

    // Pixel 0 sits in the top nibble, so the normal order counts down
    assign nib_sel = hflip_r ? cnt_r : ~cnt_r;
    assign color   = pat_r[{nib_sel, 2'b00} +: 4];

    assign busy       = busy_r;
    assign last_pixel = busy_r && (cnt_r == 3'd7);
    assign wr_en      = busy_r;
    assign wr_idx     = base_r + lb_idx_t'(cnt_r);
    assign wr_data    = {pal_r, color};

    ////////////////////////////////////////////////////////////////////////////
    // Control
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset) begin
            busy_r <= 1'b0;
            cnt_r  <= '0;
        end else if (load) begin
            // Also taken on the last pixel, back to back tiles
            busy_r <= 1'b1;
            cnt_r  <= '0;
        end else if (busy_r) begin
            cnt_r <= cnt_r + 3'd1;
            if (cnt_r == 3'd7) begin
                busy_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            pat_r   <= pattern;
            hflip_r <= hflip;
            pal_r   <= palette;
            base_r  <= tile_x;
        end
    end

endmodule

// ==== hw/gfx_linebuf.sv ====
`timescale 1ns/1ps

module gfx_linebuf (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic             wr_en,
    input  gfx_pkg::lb_idx_t wr_idx,
    input  gfx_pkg::pixel_t  wr_data,
    input  gfx_pkg::lb_idx_t rd_idx,
    output gfx_pkg::pixel_t  rd_data
);

    import gfx_pkg::*;

    // Both banks in one array, bank select as the top address bit
    localparam int DEPTH = 2 * (1 << LB_IDX_W);

    pixel_t mem [DEPTH];
    logic   bank_sel_r;

    always_ff @(posedge clk) begin
        if (reset) begin
            bank_sel_r <= 1'b0;
        end else if (start) begin
            bank_sel_r <= ~bank_sel_r;
        end
    end

    // Renderer writes one bank, display reads the other
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[{bank_sel_r, wr_idx}] <= wr_data;
        end
        rd_data <= mem[{~bank_sel_r, rd_idx}];
    end

endmodule

// ==== hw/gfx_tile_line.sv ====
`timescale 1ns/1ps

module gfx_tile_line #(
    parameter int TILES_PER_LINE = gfx_pkg::TILES_PER_LINE_DEF
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             start,
    input  logic [8:0]       scrx,
    input  logic [7:0]       scry,
    input  logic [7:0]       vline,
    input  gfx_pkg::vword_t  vdata,
    input  gfx_pkg::lb_idx_t lb_rdidx,
    output gfx_pkg::vaddr_t  vaddr,
    output gfx_pkg::pixel_t  lb_rddata,
    output logic             line_done
);

    import gfx_pkg::*;

    // Fetch to counter
    logic [5:0] col;
    logic       last_tile;
    logic       map_fetch;
    logic       tile_issue;

    // Fetch to shifter
    pattern_t   pattern;
    logic       hflip;
    palette_t   palette;
    lb_idx_t    tile_x;
    logic       shifter_busy;
    logic       shifter_last;

    // Shifter to line buffer
    logic       wr_en;
    lb_idx_t    wr_idx;
    pixel_t     wr_data;

    ////////////////////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////////////////////
    gfx_fetch_fsm u_fetch (
        .clk(clk), .reset(reset), .start(start),
        .vline(vline), .scry(scry), .vdata(vdata),
        .col(col), .last_tile(last_tile),
        .shifter_busy(shifter_busy), .shifter_last(shifter_last),
        .vaddr(vaddr), .map_fetch(map_fetch), .tile_issue(tile_issue),
        .pattern(pattern), .hflip(hflip), .palette(palette),
        .line_done(line_done)
    );

    gfx_col_counter #(.TILES_PER_LINE(TILES_PER_LINE)) u_col (
        .clk(clk), .reset(reset), .start(start), .scrx(scrx),
        .map_fetch(map_fetch), .tile_issue(tile_issue),
        .col(col), .last_tile(last_tile), .tile_x(tile_x)
    );

    gfx_pixel_shifter u_shifter (
        .clk(clk), .reset(reset), .load(tile_issue), .tile_x(tile_x),
        .pattern(pattern), .hflip(hflip), .palette(palette),
        .busy(shifter_busy), .last_pixel(shifter_last),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
    );

    gfx_linebuf u_linebuf (
        .clk(clk), .reset(reset), .start(start),
        .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data),
        .rd_idx(lb_rdidx), .rd_data(lb_rddata)
    );

endmodule

// ==== dv/gfx_tile_line_assert.sv ====
`timescale 1ns/1ps

module gfx_tile_line_assert (
    input logic            clk,
    input logic            reset,
    input logic            start,
    input logic [8:0]      scrx,
    input logic [7:0]      scry,
    input logic [7:0]      vline,
    input gfx_pkg::vaddr_t vaddr,
    input logic            wr_en,
    input logic            line_done
);

    import gfx_pkg::*;

    logic [7:0] tline;

    assign tline = vline - FIRST_LINE + scry;

    done_after_reset: assert property (@(posedge clk) reset |=> !line_done)
        else $error("line_done high in the cycle after reset");

    // No pixel writes once the line is finished
    no_write_when_done: assert property (@(posedge clk) disable iff (reset)
        line_done |=> !wr_en)
        else $error("pixel write while line_done is high");

    start_map_addr: assert property (@(posedge clk) disable iff (reset)
        start |-> vaddr == {2'b00, tline[7:3], scrx[8:3]})
        else $error("vaddr in start cycle is not the first map address");

endmodule

bind gfx_tile_line gfx_tile_line_assert u_assert (
    .clk(clk), .reset(reset), .start(start),
    .scrx(scrx), .scry(scry), .vline(vline),
    .vaddr(vaddr), .wr_en(wr_en), .line_done(line_done)
);

// ==== dv/tb_gfx_tile_line.sv ====
`timescale 1ns/1ps

module tb_gfx_tile_line;

    import gfx_pkg::*;

    localparam int VRAM_WORDS   = 8192;
    localparam int LINE_PIXELS  = 320;
    localparam int LINE_TIMEOUT = 2000;

    logic       clk = 1'b0;
    logic       reset;
    logic       start;
    logic [8:0] scrx;
    logic [7:0] scry;
    logic [7:0] vline;
    lb_idx_t    lb_rdidx;
    vaddr_t     vaddr;
    vword_t     vdata;
    pixel_t     lb_rddata;
    logic       line_done;

    vword_t vram [VRAM_WORDS];
    vaddr_t ram_addr_q = '0;
    pixel_t exp_line [LINE_PIXELS];
    int     seed;

    gfx_tile_line DUT (
        .clk(clk), .reset(reset), .start(start),
        .scrx(scrx), .scry(scry), .vline(vline),
        .vdata(vdata), .lb_rdidx(lb_rdidx),
        .vaddr(vaddr), .lb_rddata(lb_rddata), .line_done(line_done)
    );

    always #5 clk = ~clk;

    // Video RAM, synchronous read
    always @(posedge clk) begin
        ram_addr_q <= vaddr;
    end
    assign vdata = vram[ram_addr_q];

    ////////////////////////////////////////////////////////////////////////////
    // Reference model and compare tasks
    ////////////////////////////////////////////////////////////////////////////
    function automatic pixel_t ref_pixel(input int x);
        logic [7:0] tl;
        int         pos;
        int         k;
        logic [5:0] col;
        logic [2:0] row;
        vword_t     entry;
        vword_t     word;
        logic [3:0] nib;
        tl    = vline - FIRST_LINE + scry;
        pos   = x + int'(scrx[2:0]);
        col   = scrx[8:3] + 6'(pos / 8);
        entry = vram[{2'b00, tl[7:3], col}];
        row   = entry[10] ? ~tl[2:0] : tl[2:0];
        k     = entry[9] ? 7 - (pos % 8) : pos % 8;
        // Pixels 4 to 7 live in the odd word
        word  = vram[{entry[8:0], row, k >= 4}];
        case (k % 4)
            0: nib = word[7:4];
            1: nib = word[3:0];
            2: nib = word[15:12];
            default: nib = word[11:8];
        endcase
        return {entry[13:12], nib};
    endfunction

    task automatic build_expected();
        int x;
        for (x = 0; x < LINE_PIXELS; x++) begin
            exp_line[x] = ref_pixel(x);
        end
    endtask

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic compare_pixel(input pixel_t got, input pixel_t exp, input int idx);
        if (got !== exp) begin
            stop_on_failure($sformatf("error: t=%0t line index %0d read %h, expected %h",
                $time, idx, got, exp));
        end
    endtask

    task automatic compare_vaddr(input vaddr_t got, input vaddr_t exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("error: t=%0t first map address %h, expected %h",
                $time, got, exp));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_tile_map(input logic hf, input logic vf, input palette_t pal);
        int a;
        for (a = 0; a < VRAM_WORDS; a++) begin
            if (a < 2048) begin
                // Tiles from 128 up, so patterns stay clear of the map
                vram[a] = {2'b00, pal, 1'b0, vf, hf, 9'(128 + a % 256)};
            end else begin
                vram[a] = 16'(a * 40503) ^ 16'(a >> 5);
            end
        end
    endtask

    task automatic randomize_vram();
        int a;
        for (a = 0; a < VRAM_WORDS; a++) begin
            vram[a] = 16'($random(seed));
        end
    endtask

    task automatic set_scroll(input logic [8:0] sx, input logic [7:0] sy,
                              input logic [7:0] vl);
        @(negedge clk);
        scrx  = sx;
        scry  = sy;
        vline = vl;
    endtask

    task automatic pulse_start();
        logic [7:0] tl;
        @(negedge clk);
        start = 1'b1;
        tl    = vline - FIRST_LINE + scry;
        #1;
        compare_vaddr(vaddr, {2'b00, tl[7:3], scrx[8:3]});
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic wait_line_done();
        int n;
        n = 0;
        while (!line_done && n < LINE_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!line_done) begin
            stop_on_failure("timeout: line_done did not rise after start");
        end
    endtask

    // One cycle of read latency, sampled on the next falling edge
    task automatic read_line();
        int i;
        @(negedge clk);
        lb_rdidx = '0;
        for (i = 0; i < LINE_PIXELS; i++) begin
            @(negedge clk);
            compare_pixel(lb_rddata, exp_line[i], i);
            lb_rdidx = lb_idx_t'(i + 1);
        end
    endtask

    task automatic render_and_check(input logic [8:0] sx, input logic [7:0] sy,
                                    input logic [7:0] vl);
        set_scroll(sx, sy, vl);
        build_expected();
        pulse_start();
        wait_line_done();
        // Second start moves the finished line to the display side
        pulse_start();
        read_line();
        wait_line_done();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic unscrolled_line();
        load_tile_map(1'b0, 1'b0, 2'd0);
        render_and_check(9'd0, 8'd0, FIRST_LINE);
    endtask

    task automatic horizontal_scroll();
        // Coarse 60 wraps past column 63, fine 5
        load_tile_map(1'b0, 1'b0, 2'd0);
        render_and_check({6'd60, 3'd5}, 8'd0, 8'd35);
    endtask

    task automatic vertical_scroll_flip();
        load_tile_map(1'b0, 1'b1, 2'd1);
        render_and_check(9'd19, 8'd203, 8'd100);
    endtask

    task automatic hflip_palette();
        load_tile_map(1'b1, 1'b0, 2'd2);
        render_and_check(9'd3, 8'd6, 8'd77);
    endtask

    task automatic double_buffering();
        load_tile_map(1'b0, 1'b0, 2'd1);
        set_scroll(9'd0, 8'd0, 8'd40);
        build_expected();
        pulse_start();
        wait_line_done();
        // New data and scroll, the first line must survive the render
        load_tile_map(1'b1, 1'b1, 2'd2);
        set_scroll(9'd77, 8'd9, 8'd150);
        pulse_start();
        wait_line_done();
        read_line();
        build_expected();
        pulse_start();
        read_line();
        wait_line_done();
    endtask

    task automatic random_lines();
        logic [8:0] sx;
        logic [7:0] sy;
        logic [7:0] vl;
        randomize_vram();
        repeat (4) begin
            sx = 9'($random(seed));
            sy = 8'($random(seed));
            vl = 8'($random(seed));
            render_and_check(sx, sy, vl);
        end
    endtask

    initial begin
        seed     = 32'hd738_8bf0;
        reset    = 1'b1;
        start    = 1'b0;
        scrx     = '0;
        scry     = '0;
        vline    = '0;
        lb_rdidx = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        unscrolled_line();
        horizontal_scroll();
        vertical_scroll_flip();
        hflip_palette();
        double_buffering();
        random_lines();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== filelist.f ====
hw/gfx_pkg.sv
hw/gfx_fetch_fsm.sv
hw/gfx_col_counter.sv
hw/gfx_pixel_shifter.sv
hw/gfx_linebuf.sv
hw/gfx_tile_line.sv
dv/gfx_tile_line_assert.sv
dv/tb_gfx_tile_line.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f filelist.f --top-module tb_gfx_tile_line \
    -o sim_tb && ./obj_dir/sim_tb > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
exit 0
